// ==== hw/mul_pkg.sv ====
// Multiply subsystem definitions
`default_nettype none

package mul_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;   // Architectural integer registers

    typedef logic [XLEN-1:0]   xlen_t;      // Operand or result word
    typedef logic [2*XLEN-1:0] dxlen_t;     // Full product
    typedef logic [4:0]        reg_addr_t;  // Destination register index

    // ----------------------------------------
    // Dispatch fields
    // ----------------------------------------
    typedef logic [1:0] unit_t;
    typedef logic [2:0] funct3_t;

    localparam unit_t UNIT_ALU = 2'd0;
    localparam unit_t UNIT_MUL = 2'd1;
    localparam unit_t UNIT_DIV = 2'd2;
    localparam unit_t UNIT_MEM = 2'd3;

    // ----------------------------------------
    // Decoded multiply kind
    // ----------------------------------------
    typedef logic [1:0] mul_kind_t;

    // Signed x signed, low doubleword; MULW when op_32 is set
    localparam mul_kind_t MUL_LO  = 2'd0;
    localparam mul_kind_t MUL_HSS = 2'd1;   // MULH
    localparam mul_kind_t MUL_HSU = 2'd2;   // MULHSU
    localparam mul_kind_t MUL_HUU = 2'd3;   // MULHU

endpackage

`default_nettype wire

// ==== hw/mul_issue.sv ====
// Multiply issue stage
`timescale 1ns/1ps
`default_nettype none

module mul_issue (
    input  wire  logic                clk_i,
    input  wire  logic                rstn_i,
    input  wire  logic                kill_i,       // Flush in-flight work
    input  wire  logic                valid_i,
    input  wire  mul_pkg::unit_t      unit_i,
    input  wire  mul_pkg::funct3_t    funct3_i,
    input  wire  logic                op_32_i,
    input  wire  mul_pkg::xlen_t      rs1_data_i,
    input  wire  mul_pkg::xlen_t      rs2_data_i,
    input  wire  mul_pkg::reg_addr_t  rd_i,
    output logic                      iss_valid_o,
    output mul_pkg::mul_kind_t        iss_kind_o,
    output logic                      iss_op_32_o,
    output mul_pkg::xlen_t            iss_src1_o,
    output mul_pkg::xlen_t            iss_src2_o,
    output mul_pkg::reg_addr_t        iss_rd_o
);
    import mul_pkg::*;

    logic      accept;
    mul_kind_t kind_d;

    // Only funct3 0..3 are multiplies, and only MUL has a word form
    assign accept = valid_i && (unit_i == UNIT_MUL) && !funct3_i[2] &&
                    (!op_32_i || (funct3_i == 3'd0));

    always_comb begin
        case (funct3_i[1:0])
            2'd0:    kind_d = MUL_LO;
            2'd1:    kind_d = MUL_HSS;
            2'd2:    kind_d = MUL_HSU;
            default: kind_d = MUL_HUU;
        endcase
    end

    // ----------------------------------------
    // Issue register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            iss_valid_o <= 1'b0;
            iss_kind_o  <= MUL_LO;
            iss_op_32_o <= 1'b0;
            iss_src1_o  <= '0;
            iss_src2_o  <= '0;
            iss_rd_o    <= '0;
        end else if (kill_i || !accept) begin
            // Empty slot carries a zero payload
            iss_valid_o <= 1'b0;
            iss_kind_o  <= MUL_LO;
            iss_op_32_o <= 1'b0;
            iss_src1_o  <= '0;
            iss_src2_o  <= '0;
            iss_rd_o    <= '0;
        end else begin
            iss_valid_o <= 1'b1;
            iss_kind_o  <= kind_d;
            iss_op_32_o <= op_32_i;
            iss_src1_o  <= rs1_data_i;
            iss_src2_o  <= rs2_data_i;
            iss_rd_o    <= rd_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_pipe.sv ====
// Two-stage integer multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_pipe (
    input  wire  logic                clk_i,
    input  wire  logic                rstn_i,
    input  wire  logic                kill_i,
    input  wire  logic                iss_valid_i,
    input  wire  mul_pkg::mul_kind_t  iss_kind_i,
    input  wire  logic                iss_op_32_i,
    input  wire  mul_pkg::xlen_t      iss_src1_i,
    input  wire  mul_pkg::xlen_t      iss_src2_i,
    input  wire  mul_pkg::reg_addr_t  iss_rd_i,
    output logic                      res_valid_o,
    output mul_pkg::reg_addr_t        res_rd_o,
    output mul_pkg::xlen_t            res_data_o
);
    import mul_pkg::*;

    // Operand folding
    xlen_t       op1;
    xlen_t       op2;
    logic        neg1;
    logic        neg2;
    xlen_t       src1_d;
    xlen_t       src2_d;
    logic        neg_d;

    // Stage 0
    logic        s0_valid_q;
    mul_kind_t   s0_kind_q;
    logic        s0_op_32_q;
    logic        s0_neg_q;
    xlen_t       s0_src1_q;
    xlen_t       s0_src2_q;
    reg_addr_t   s0_rd_q;
    logic [95:0] prod_lo;
    logic [95:0] prod_hi;
    xlen_t       res_32_raw;
    xlen_t       res_32;
    logic        s0_word_done;

    // Stage 1
    logic        s1_valid_q;
    mul_kind_t   s1_kind_q;
    logic        s1_neg_q;
    logic [95:0] prod_lo_q;
    logic [95:0] prod_hi_q;
    reg_addr_t   s1_rd_q;
    dxlen_t      sum_128;
    dxlen_t      sum_128_def;
    xlen_t       res_64;

    // Word operands are the sign-extended low words
    assign op1  = iss_op_32_i ? {{32{iss_src1_i[31]}}, iss_src1_i[31:0]} : iss_src1_i;
    assign op2  = iss_op_32_i ? {{32{iss_src2_i[31]}}, iss_src2_i[31:0]} : iss_src2_i;
    assign neg1 = op1[XLEN-1];
    assign neg2 = op2[XLEN-1];

    // Magnitudes of signed operands, and the sign of the product
    always_comb begin
        src1_d = op1;
        src2_d = op2;
        neg_d  = 1'b0;
        case (iss_kind_i)
            MUL_LO, MUL_HSS: begin
                if (neg1) src1_d = ~op1 + 1'b1;
                if (neg2) src2_d = ~op2 + 1'b1;
                neg_d = neg1 ^ neg2;
            end
            MUL_HSU: begin
                if (neg1) src1_d = ~op1 + 1'b1;
                neg_d = neg1;                   // Second operand unsigned
            end
            default: neg_d = 1'b0;              // MULHU
        endcase
    end

    // ----------------------------------------
    // Stage 0
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s0_valid_q <= 1'b0;
        end else begin
            s0_valid_q <= iss_valid_i & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            s0_kind_q  <= iss_kind_i;
            s0_op_32_q <= iss_op_32_i;
            s0_neg_q   <= neg_d;
            s0_src1_q  <= src1_d;
            s0_src2_q  <= src2_d;
            s0_rd_q    <= iss_rd_i;
        end
    end

    // Two 64x32 partial products
    assign prod_lo = {32'b0, s0_src1_q} * {64'b0, s0_src2_q[31:0]};
    assign prod_hi = {32'b0, s0_src1_q} * {64'b0, s0_src2_q[63:32]};

    // MULW finishes here with only the low product
    assign res_32_raw = s0_neg_q ? ~prod_lo[XLEN-1:0] + 1'b1 : prod_lo[XLEN-1:0];
    assign res_32     = {{32{res_32_raw[31]}}, res_32_raw[31:0]};

    assign s0_word_done = s0_valid_q & s0_op_32_q;

    // ----------------------------------------
    // Stage 1
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= s0_valid_q & ~s0_op_32_q & ~kill_i;  // Word ops skip
        end
    end

    always_ff @(posedge clk_i) begin
        if (s0_valid_q && !s0_op_32_q) begin
            s1_kind_q <= s0_kind_q;
            s1_neg_q  <= s0_neg_q;
            prod_lo_q <= prod_lo;
            prod_hi_q <= prod_hi;
            s1_rd_q   <= s0_rd_q;
        end
    end

    // High partial product is weighted by 2^32
    assign sum_128     = {32'b0, prod_lo_q} + {prod_hi_q, 32'b0};
    assign sum_128_def = s1_neg_q ? ~sum_128 + 1'b1 : sum_128;

    assign res_64 = (s1_kind_q == MUL_LO) ? sum_128_def[XLEN-1:0]
                                          : sum_128_def[2*XLEN-1:XLEN];

    // ----------------------------------------
    // Output select
    // ----------------------------------------
    // Stage 0 wins; the issue rule keeps both from finishing together
    assign res_valid_o = ~kill_i & (s0_word_done | s1_valid_q);
    assign res_rd_o    = s0_word_done ? s0_rd_q : s1_rd_q;
    assign res_data_o  = s0_word_done ? res_32 : res_64;

endmodule

`default_nettype wire

// ==== hw/mul_result_regs.sv ====
// Multiply result register file
`timescale 1ns/1ps
`default_nettype none

module mul_result_regs (
    input  wire  logic                clk_i,
    input  wire  logic                rstn_i,
    input  wire  logic                res_valid_i,
    input  wire  mul_pkg::reg_addr_t  res_rd_i,
    input  wire  mul_pkg::xlen_t      res_data_i,
    input  wire  mul_pkg::reg_addr_t  rd_addr_i,
    output mul_pkg::xlen_t            rd_data_o,
    output logic                      done_o,
    output mul_pkg::reg_addr_t        done_rd_o
);
    import mul_pkg::*;

    xlen_t regs_q [NUM_REGS];

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (res_valid_i && (res_rd_i != '0)) begin
            regs_q[res_rd_i] <= res_data_i;     // x0 is never written
        end
    end

    // Completion pulse for every result including x0
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_o    <= 1'b0;
            done_rd_o <= '0;
        end else begin
            done_o    <= res_valid_i;
            done_rd_o <= res_rd_i;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs_q[rd_addr_i];

endmodule

`default_nettype wire

// ==== hw/mul_subsystem.sv ====
// Multiply execute subsystem
`timescale 1ns/1ps
`default_nettype none

module mul_subsystem (
    input  wire  logic                clk_i,
    input  wire  logic                rstn_i,
    input  wire  logic                kill_i,
    input  wire  logic                valid_i,
    input  wire  mul_pkg::unit_t      unit_i,
    input  wire  mul_pkg::funct3_t    funct3_i,
    input  wire  logic                op_32_i,
    input  wire  mul_pkg::xlen_t      rs1_data_i,
    input  wire  mul_pkg::xlen_t      rs2_data_i,
    input  wire  mul_pkg::reg_addr_t  rd_i,
    input  wire  mul_pkg::reg_addr_t  rd_addr_i,
    output mul_pkg::xlen_t            rd_data_o,
    output logic                      done_o,
    output mul_pkg::reg_addr_t        done_rd_o
);
    import mul_pkg::*;

    // Issue to pipeline
    logic      iss_valid;
    mul_kind_t iss_kind;
    logic      iss_op_32;
    xlen_t     iss_src1;
    xlen_t     iss_src2;
    reg_addr_t iss_rd;

    // Pipeline to result registers
    logic      res_valid;
    reg_addr_t res_rd;
    xlen_t     res_data;

    mul_issue u_issue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .valid_i     (valid_i),
        .unit_i      (unit_i),
        .funct3_i    (funct3_i),
        .op_32_i     (op_32_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .rd_i        (rd_i),
        .iss_valid_o (iss_valid),
        .iss_kind_o  (iss_kind),
        .iss_op_32_o (iss_op_32),
        .iss_src1_o  (iss_src1),
        .iss_src2_o  (iss_src2),
        .iss_rd_o    (iss_rd)
    );

    mul_pipe u_pipe (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .iss_valid_i (iss_valid),
        .iss_kind_i  (iss_kind),
        .iss_op_32_i (iss_op_32),
        .iss_src1_i  (iss_src1),
        .iss_src2_i  (iss_src2),
        .iss_rd_i    (iss_rd),
        .res_valid_o (res_valid),
        .res_rd_o    (res_rd),
        .res_data_o  (res_data)
    );

    mul_result_regs u_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .res_valid_i (res_valid),
        .res_rd_i    (res_rd),
        .res_data_i  (res_data),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .done_o      (done_o),
        .done_rd_o   (done_rd_o)
    );

endmodule

`default_nettype wire

// ==== bench/mul_subsystem_sva.sv ====
// Multiply subsystem properties
`timescale 1ns/1ps
`default_nettype none

module mul_subsystem_sva (
    input  wire  logic                clk_i,
    input  wire  logic                rstn_i,
    input  wire  logic                kill_i,
    input  wire  logic                iss_valid_i,
    input  wire  logic                iss_op_32_i,
    input  wire  logic                done_o,
    input  wire  mul_pkg::reg_addr_t  rd_addr_i,
    input  wire  mul_pkg::xlen_t      rd_data_o
);
    import mul_pkg::*;

    int fail_count = 0;     // Failed properties, summed up by the testbench

    // A word op right behind a doubleword op would collide at the output
    word_after_dword: assert property (@(posedge clk_i) disable iff (!rstn_i || kill_i)
        (iss_valid_i && !iss_op_32_i) |=> !(iss_valid_i && iss_op_32_i))
        else begin
            $error("word op issued right after a doubleword op");
            fail_count++;
        end

    // Reset and the first cycles after its release stay quiet
    no_done_in_reset: assert property (@(posedge clk_i) !rstn_i |-> (!done_o) [*3])
        else begin
            $error("done_o high during or right after reset");
            fail_count++;
        end

    // Both stages are flushed, so the next two cycles stay quiet
    quiet_after_kill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        kill_i |=> !done_o ##1 !done_o)
        else begin
            $error("done_o within two cycles of a kill");
            fail_count++;
        end

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rd_addr_i == '0) |-> (rd_data_o == '0))
        else begin
            $error("x0 read returned a nonzero value");
            fail_count++;
        end

endmodule

bind mul_subsystem mul_subsystem_sva u_sva (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .kill_i      (kill_i),
    .iss_valid_i (iss_valid),
    .iss_op_32_i (iss_op_32),
    .done_o      (done_o),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o)
);

`default_nettype wire

// ==== bench/tb_mul_subsystem.sv ====
// Multiply subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mul_subsystem;
    import mul_pkg::*;

    localparam int NUM_TESTS = 24;
    localparam int LIMIT     = NUM_TESTS * 6 + 50;   // Cycle budget

    logic      clk_i;
    logic      rstn_i;
    logic      kill_i;
    logic      valid_i;
    unit_t     unit_i;
    funct3_t   funct3_i;
    logic      op_32_i;
    xlen_t     rs1_data_i;
    xlen_t     rs2_data_i;
    reg_addr_t rd_i;
    reg_addr_t rd_addr_i;
    xlen_t     rd_data_o;
    logic      done_o;
    reg_addr_t done_rd_o;

    // Test table columns
    string     name_q   [NUM_TESTS];
    unit_t     unit_q   [NUM_TESTS];
    funct3_t   f3_q     [NUM_TESTS];
    logic      op32_q   [NUM_TESTS];
    xlen_t     a_q      [NUM_TESTS];
    xlen_t     b_q      [NUM_TESTS];
    reg_addr_t rd_q     [NUM_TESTS];
    logic      chain_q  [NUM_TESTS];  // Issue right behind the previous entry
    logic      kill_q   [NUM_TESTS];
    xlen_t     exp_q    [NUM_TESTS];
    int        err_q    [NUM_TESTS];

    int        ntests = 0;
    int        cyc    = 0;
    int        seed   = 32'hc8a;
    int        passed = 0;
    int        failed = 0;

    mul_subsystem dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Cycle count and timeout
    // ----------------------------------------
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Run timed out after %0d cycles", cyc);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic add_test(input string nm, input unit_t u, input funct3_t f,
                            input logic o, input xlen_t a, input xlen_t b,
                            input reg_addr_t r, input logic ch, input logic kl,
                            input xlen_t e);
        name_q[ntests]  = nm;
        unit_q[ntests]  = u;
        f3_q[ntests]    = f;
        op32_q[ntests]  = o;
        a_q[ntests]     = a;
        b_q[ntests]     = b;
        rd_q[ntests]    = r;
        chain_q[ntests] = ch;
        kill_q[ntests]  = kl;
        exp_q[ntests]   = e;
        err_q[ntests]   = 0;
        ntests++;
    endtask

    // RISC-V M-extension product from 128-bit extended operands
    function automatic xlen_t ref_product(input funct3_t f, input logic o,
                                          input xlen_t a, input xlen_t b);
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        if (o) begin
            ea = {{96{a[31]}}, a[31:0]};
            eb = {{96{b[31]}}, b[31:0]};
            p  = ea * eb;
            return {{32{p[31]}}, p[31:0]};
        end
        ea = (f == 3'd3) ? {64'b0, a} : {{64{a[63]}}, a};
        eb = (f >= 3'd2) ? {64'b0, b} : {{64{b[63]}}, b};
        p  = ea * eb;
        return (f == 3'd0) ? p[63:0] : p[127:64];
    endfunction

    function automatic logic is_accepted(input int k);
        return (unit_q[k] == UNIT_MUL) && (f3_q[k] < 3'd4) && (!op32_q[k] || f3_q[k] == 3'd0);
    endfunction

    // Issue a group of entries back to back, then check completions and registers
    task automatic run_group(input int first, input int last);
        int   exp_cyc [NUM_TESTS];
        int   stop;
        logic hit;
        stop = 0;
        for (int k = first; k < last; k++) begin
            @(negedge clk_i);
            valid_i    = 1'b1;
            unit_i     = unit_q[k];
            funct3_i   = f3_q[k];
            op_32_i    = op32_q[k];
            rs1_data_i = a_q[k];
            rs2_data_i = b_q[k];
            rd_i       = rd_q[k];
            if (is_accepted(k) && !kill_q[k])
                exp_cyc[k] = cyc + 1 + (op32_q[k] ? 2 : 3);
            else
                exp_cyc[k] = -1;
            stop = cyc + 5;
        end
        for (int n = 0; cyc < stop; n++) begin
            @(negedge clk_i);
            valid_i = 1'b0;
            kill_i  = (n == 0) ? kill_q[last-1] : 1'b0;   // Kill the cycle after issue
            hit = 1'b0;
            for (int k = first; k < last; k++) begin
                if (exp_cyc[k] == cyc) begin
                    hit = 1'b1;
                    assert (done_o && done_rd_o == rd_q[k]) else begin
                        err_q[k]++;
                        $display("%s: done_o missing or for the wrong register", name_q[k]);
                    end
                end
            end
            if (!hit) begin
                assert (!done_o) else begin
                    err_q[last-1]++;
                    $display("%s: done_o came when no result was due", name_q[last-1]);
                end
            end
        end
        for (int k = first; k < last; k++) begin
            rd_addr_i = rd_q[k];
            #10;
            assert (rd_data_o === exp_q[k]) else begin
                err_q[k]++;
                $display("MISMATCH %s expected %h actual %h", name_q[k], exp_q[k], rd_data_o);
            end
            if (err_q[k] == 0) begin
                passed++;
                $display("PASS %s", name_q[k]);
            end else begin
                failed++;
                $display("FAIL %s", name_q[k]);
            end
        end
    endtask

    initial begin
        funct3_t f;
        logic    o;
        xlen_t   a;
        xlen_t   b;
        int      k;
        int      g_end;
        rstn_i     = 1'b0;
        kill_i     = 1'b0;
        valid_i    = 1'b0;
        unit_i     = UNIT_ALU;
        funct3_i   = '0;
        op_32_i    = 1'b0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        rd_i       = '0;
        rd_addr_i  = '0;

        add_test("mul_pos", UNIT_MUL, 3'd0, 0, 64'd3, 64'd5, 5'd1, 0, 0, 64'd15);
        add_test("mul_neg", UNIT_MUL, 3'd0, 0, -64'sd7, -64'sd6, 5'd2, 0, 0, 64'd42);
        add_test("mul_mixed", UNIT_MUL, 3'd0, 0, 64'h1_0000_0000, -64'sd2, 5'd3, 0, 0,
                 64'hFFFF_FFFE_0000_0000);
        add_test("mulh_minneg", UNIT_MUL, 3'd1, 0, 64'h8000_0000_0000_0000,
                 64'h8000_0000_0000_0000, 5'd4, 0, 0, 64'h4000_0000_0000_0000);
        add_test("mulhsu_ones", UNIT_MUL, 3'd2, 0, '1, '1, 5'd5, 0, 0, '1);
        add_test("mulhu_ones", UNIT_MUL, 3'd3, 0, '1, '1, 5'd6, 0, 0, 64'hFFFF_FFFF_FFFF_FFFE);
        add_test("mulw_lowword", UNIT_MUL, 3'd0, 1, 64'hDEAD_BEEF_0000_FFFF,
                 64'h1234_5678_0001_0001, 5'd7, 0, 0, '1);
        add_test("b2b_mul", UNIT_MUL, 3'd0, 0, 64'd100, 64'd200, 5'd8, 0, 0, 64'd20000);
        add_test("b2b_mulhu", UNIT_MUL, 3'd3, 0, 64'h1_0000_0000, 64'h1_0000_0000, 5'd9,
                 1, 0, 64'd1);
        add_test("word_first", UNIT_MUL, 3'd0, 1, 64'h0000_0000_FFFF_FFFD, 64'd4, 5'd10,
                 0, 0, 64'hFFFF_FFFF_FFFF_FFF4);
        add_test("dword_second", UNIT_MUL, 3'd0, 0, 64'd7, 64'd9, 5'd11, 1, 0, 64'd63);
        add_test("killed", UNIT_MUL, 3'd0, 0, 64'd5, 64'd5, 5'd12, 0, 1, 64'd0);
        add_test("wrong_unit", UNIT_ALU, 3'd0, 0, 64'd5, 64'd5, 5'd13, 0, 0, 64'd0);
        add_test("div_funct3", UNIT_MUL, 3'd4, 0, 64'd5, 64'd5, 5'd14, 0, 0, 64'd0);
        add_test("word_mulh", UNIT_MUL, 3'd1, 1, 64'd5, 64'd5, 5'd15, 0, 0, 64'd0);
        add_test("to_x0", UNIT_MUL, 3'd0, 0, 64'd9, 64'd9, 5'd0, 0, 0, 64'd0);
        for (int i = 0; i < 8; i++) begin
            f = $random(seed) & 3;
            o = (f == 3'd0) ? $random(seed) & 1 : 1'b0;
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            add_test($sformatf("rand_%0d", i), UNIT_MUL, f, o, a, b, 5'(16 + i), 0, 0,
                     ref_product(f, o, a, b));
        end

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        k = 0;
        while (k < ntests) begin
            g_end = k + 1;
            while (g_end < ntests && chain_q[g_end]) g_end++;
            run_group(k, g_end);
            k = g_end;
        end

        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 ntests, passed, failed, dut.u_sva.fail_count);
        if (failed == 0 && dut.u_sva.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/mul_pkg.sv
hw/mul_issue.sv
hw/mul_pipe.sv
hw/mul_result_regs.sv
hw/mul_subsystem.sv
bench/mul_subsystem_sva.sv
bench/tb_mul_subsystem.sv

// ==== Bender.yml ====
package:
  name: mul_subsystem

sources:
  - files:
      - hw/mul_pkg.sv
      - hw/mul_issue.sv
      - hw/mul_pipe.sv
      - hw/mul_result_regs.sv
      - hw/mul_subsystem.sv
  - target: test
    files:
      - bench/mul_subsystem_sva.sv
      - bench/tb_mul_subsystem.sv
